// File: src.f
hw/salamander_pkg.sv
hw/ioctl_region_decoder.sv
hw/sdram_prog_writer.sv
hw/board_inputs.sv
hw/salamander_loader_top.sv
dv/salamander_loader_assertions.sv
dv/tb_salamander_loader.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_salamander_loader
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/loader_cases.txt
# kind index addr data joy0 joy1 x0 x1 x2 x3, all hex
# x for rom: bank addr mask word (bram: addr data cs), dip: sw1 sw2 sw3 done, joy: in0 in1 in2
rom 0000 0000012 A5 0000 0000 0 000012 1 A5A5
rom 0000 001FFFF 01 0000 0000 0 01FFFF 1 0101
rom 0000 002ABCD 5A 0000 0000 0 00ABCD 2 5A5A
rom 0000 0031234 3C 0000 0000 0 011234 2 3C3C
rom 0000 0040007 80 0000 0000 1 000003 1 8080
rom 0000 005FFFE 7E 0000 0000 1 00FFFF 2 7E7E
rom 0000 0060010 4E 0000 0000 0 020010 1 4E4E
rom 0000 007ABCD 75 0000 0000 0 02ABCD 2 7575
rom 0000 0080123 11 0000 0000 0123 11 2 0
rom 0000 008C001 EE 0000 0000 C001 EE 1 0
rom 0000 00F7FFF 99 0000 0000 7FFF 99 2 0
joy 0000 0000000 00 0000 0000 E0 C0 C0 0
joy 0000 0000000 00 0381 0336 FF C2 F9 0
dip 00FE 0000003 00 0000 0000 FF 42 F 0
dip 00FE 0000000 5A 0000 0000 5A 42 F 0
dip 00FE 0000001 3C 0000 0000 5A 3C F 0
dip 00FE 0000002 A6 0000 0000 5A 3C 6 1
dip 00FE 0000000 00 0000 0000 5A 3C 6 1
rom 0000 0000040 12 0000 0000 0 3FFFFF 0 FFFF
rom 0000 0080010 34 0000 0000 0 3FFFFF 0 FFFF
joy 0000 0000000 00 0000 0000 C0 40 C0 0
joy 0000 0000000 00 0035 0100 C2 7A C0 0

// File: dv/tb_salamander_loader.sv
module tb_salamander_loader;

    logic                            i_EMU_MCLK;
    logic                            i_EMU_INITRST;
    salamander_pkg::ioctl_t          i_ioctl;
    logic                            o_ioctl_wait;
    logic                            i_sdram_init;
    logic                            i_prog_sdram_ack;
    logic                            o_prog_sdram_en;
    logic                            o_prog_sdram_wr;
    salamander_pkg::sdram_prog_cmd_t o_prog_sdram;
    logic                            o_prog_bram_en;
    logic                            o_prog_bram_wr;
    salamander_pkg::bram_prog_cmd_t  o_prog_bram;
    salamander_pkg::joystick_t       i_joystick0;
    salamander_pkg::joystick_t       i_joystick1;
    salamander_pkg::board_in_t       o_in0;
    salamander_pkg::board_in_t       o_in1;
    salamander_pkg::board_in_t       o_in2;
    salamander_pkg::dipsw_t          o_dipsw;
    logic                            o_download_done;

    // index, addr, data, joy0 and joy1 per case, then four expected values
    logic [23:0] kinds [0:63];
    logic [31:0] cols  [0:63][0:8];
    int          n_cases      = 0;
    logic        cases_loaded = 1'b0;
    logic        done_seen    = 1'b0;
    logic [31:0] lcg_state    = 32'd27;

    salamander_loader_top salamander_loader_top_inst (.*);

    initial begin
        i_EMU_MCLK = 1'b0;
        forever #4 i_EMU_MCLK = ~i_EMU_MCLK;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({17'd0, lcg_state[30:16]});
    endfunction

    task automatic next_cycle();
        @(posedge i_EMU_MCLK);
        #1;
    endtask

    task automatic check_value(input logic [47:0] got, input logic [47:0] want,
                               input string what);
        if (got !== want) begin
            $display("[ERROR] %0t: %s mismatch, got %0h expected %0h", $time, what, got, want);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          r;
        string       line;
        logic [23:0] kind;
        logic [31:0] v [0:8];
        fd = $fopen("dv/loader_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file dv/loader_cases.txt");
            $display("Some tests failed");
            $fatal(1, "no case file");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    r = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind, v[0], v[1],
                                v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (r != 10) begin
                        $display("malformed line in the case file: %s", line);
                        $display("Some tests failed");
                        $fatal(1, "bad case file");
                    end else begin
                        kinds[n_cases] = kind;
                        for (int c = 0; c < 9; c++) begin
                            cols[n_cases][c] = v[c];
                        end
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // host side of the download bus with one byte per write
    task automatic drive_write(input int n);
        while (o_ioctl_wait) begin
            next_cycle();
        end
        i_ioctl.index = cols[n][0][15:0];
        i_ioctl.addr  = cols[n][1][26:0];
        i_ioctl.data  = cols[n][2][7:0];
        i_ioctl.wr    = 1'b1;
        next_cycle();
        i_ioctl.wr    = 1'b0;
    endtask

    task automatic run_rom_case(input int n);
        salamander_pkg::sdram_prog_cmd_t want_cmd;
        want_cmd = {cols[n][5][1:0], cols[n][6][21:0], cols[n][7][1:0], cols[n][8][15:0]};
        drive_write(n);
        if (done_seen) begin
            repeat (3) begin
                check_value(48'({o_prog_sdram_en, o_prog_sdram_wr, o_prog_bram_en,
                                 o_prog_bram_wr}), 48'd0, "outputs while done");
                check_value(48'(o_prog_sdram), 48'(want_cmd), "idle sdram command");
                next_cycle();
            end
        end else if (cols[n][1][19]) begin
            check_value(48'({o_prog_sdram_en, o_prog_bram_en, o_prog_bram_wr}), 48'b011,
                        "bram enables");
            check_value(48'(o_prog_bram), 48'({cols[n][5][15:0], cols[n][6][7:0],
                        cols[n][7][1:0]}), "bram command");
            next_cycle();
            check_value(48'(o_prog_bram_wr), 48'd0, "bram write after wr fell");
        end else begin
            while (!o_prog_sdram_wr) begin
                next_cycle();
            end
            check_value(48'({o_prog_sdram_en, o_prog_bram_en}), 48'b10, "sdram enables");
            check_value(48'(o_prog_sdram), 48'(want_cmd), "sdram command");
            // host stalled while the write waits for ack
            while (o_prog_sdram_wr) begin
                check_value(48'({o_ioctl_wait, o_prog_sdram}), 48'({1'b1, want_cmd}),
                            "held write and wait");
                next_cycle();
            end
            check_value(48'(o_ioctl_wait), 48'd0, "wait after ack");
        end
    endtask

    task automatic run_dip_case(input int n);
        drive_write(n);
        check_value(48'({o_dipsw, o_download_done}), 48'({cols[n][5][7:0], cols[n][6][7:0],
                    cols[n][7][3:0], cols[n][8][0]}), "dip switches and done");
        check_value(48'({o_prog_sdram_en, o_prog_bram_en}), 48'd0, "enables after dip write");
        done_seen = cols[n][8][0];
    endtask

    task automatic run_joy_case(input int n);
        i_joystick0 = cols[n][3][15:0];
        i_joystick1 = cols[n][4][15:0];
        next_cycle();
        check_value(48'({o_in0, o_in1, o_in2}), 48'({cols[n][5][7:0], cols[n][6][7:0],
                    cols[n][7][7:0]}), "input ports");
    endtask

    ////////////////////
    // memory side ack with random latency

    initial begin : ack_model
        int delay;
        i_prog_sdram_ack = 1'b0;
        forever begin
            next_cycle();
            if (o_prog_sdram_wr) begin
                delay = 1 + (next_rand() % 6);
                repeat (delay - 1) begin
                    next_cycle();
                end
                i_prog_sdram_ack = 1'b1;
                next_cycle();
                i_prog_sdram_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (cases_loaded);
        repeat (n_cases * 20 + 200) @(posedge i_EMU_MCLK);
        $display("watchdog expired, the run timed out before all cases finished");
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    initial begin : main_sequence
        i_EMU_INITRST = 1'b1;
        i_ioctl       = '0;
        i_sdram_init  = 1'b1;
        i_joystick0   = '0;
        i_joystick1   = '0;
        load_cases();
        cases_loaded  = 1'b1;
        repeat (4) @(posedge i_EMU_MCLK);
        #1;
        i_EMU_INITRST = 1'b0;
        check_value(48'({o_prog_sdram_en, o_prog_sdram_wr, o_prog_bram_en, o_prog_bram_wr,
                         o_download_done}), 48'd0, "outputs after reset");
        check_value(48'(o_ioctl_wait), 48'd1, "wait during sdram init");
        repeat (10) next_cycle();
        i_sdram_init = 1'b0;
        for (int n = 0; n < n_cases; n++) begin
            if (kinds[n] == "rom") begin
                run_rom_case(n);
            end else if (kinds[n] == "dip") begin
                run_dip_case(n);
            end else begin
                run_joy_case(n);
            end
        end
        if (n_cases > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("the case file holds no cases");
            $display("Some tests failed");
            $fatal(1, "empty case file");
        end
    end

endmodule

// File: dv/salamander_loader_assertions.sv
module salamander_loader_assertions (
    input logic                            i_EMU_MCLK,
    input logic                            i_EMU_INITRST,
    input logic                            i_done,
    input logic                            i_wr,
    input logic                            i_ack,
    input salamander_pkg::sdram_prog_cmd_t i_cmd,
    input salamander_pkg::dipsw_t          i_dipsw
);

    // command held until the memory side takes it
    cmd_hold: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        (i_wr && !i_ack && !i_done) |=> $stable(i_cmd))
        else $error("sdram command changed before acknowledge");

    wr_drop: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        (i_wr && i_ack) |=> !i_wr)
        else $error("sdram write still high after acknowledge");

    // loader frozen once the download is done
    done_no_wr: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_done |=> !i_wr)
        else $error("sdram write high while download done");

    done_dipsw: assert property (@(posedge i_EMU_MCLK) disable iff (i_EMU_INITRST)
        i_done |=> $stable(i_dipsw))
        else $error("dip switches changed while download done");

endmodule

bind sdram_prog_writer salamander_loader_assertions writer_checks (
    .i_EMU_MCLK    (i_EMU_MCLK),
    .i_EMU_INITRST (i_EMU_INITRST),
    .i_done        (i_download_done),
    .i_wr          (o_prog_sdram_wr),
    .i_ack         (i_prog_sdram_ack),
    .i_cmd         (o_prog_sdram),
    .i_dipsw       ('0)
);

bind board_inputs salamander_loader_assertions switch_checks (
    .i_EMU_MCLK    (i_EMU_MCLK),
    .i_EMU_INITRST (i_EMU_INITRST),
    .i_done        (o_download_done),
    .i_wr          (1'b0),
    .i_ack         (1'b0),
    .i_cmd         ('0),
    .i_dipsw       (o_dipsw)
);

// File: hw/salamander_loader_top.sv
module salamander_loader_top (
    input  logic                            i_EMU_MCLK,
    input  logic                            i_EMU_INITRST,
    input  salamander_pkg::ioctl_t          i_ioctl,
    output logic                            o_ioctl_wait,
    input  logic                            i_sdram_init,
    input  logic                            i_prog_sdram_ack,
    output logic                            o_prog_sdram_en,
    output logic                            o_prog_sdram_wr,
    output salamander_pkg::sdram_prog_cmd_t o_prog_sdram,
    output logic                            o_prog_bram_en,
    output logic                            o_prog_bram_wr,
    output salamander_pkg::bram_prog_cmd_t  o_prog_bram,
    input  salamander_pkg::joystick_t       i_joystick0,
    input  salamander_pkg::joystick_t       i_joystick1,
    output salamander_pkg::board_in_t       o_in0,
    output salamander_pkg::board_in_t       o_in1,
    output salamander_pkg::board_in_t       o_in2,
    output salamander_pkg::dipsw_t          o_dipsw,
    output logic                            o_download_done
);

    logic                      sdram_byte_wr;
    salamander_pkg::dipsw_wr_t dipsw_wr;

    // host stalls during sdram init and while a write is pending
    assign o_ioctl_wait = i_sdram_init | o_prog_sdram_wr;

    ioctl_region_decoder ioctl_region_decoder_inst (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .i_ioctl         (i_ioctl),
        .i_download_done (o_download_done),
        .o_prog_sdram_en (o_prog_sdram_en),
        .o_sdram_byte_wr (sdram_byte_wr),
        .o_prog_bram_en  (o_prog_bram_en),
        .o_prog_bram_wr  (o_prog_bram_wr),
        .o_prog_bram     (o_prog_bram),
        .o_dipsw_wr      (dipsw_wr)
    );

    sdram_prog_writer sdram_prog_writer_inst (
        .i_EMU_MCLK       (i_EMU_MCLK),
        .i_EMU_INITRST    (i_EMU_INITRST),
        .i_ioctl          (i_ioctl),
        .i_sdram_byte_wr  (sdram_byte_wr),
        .i_download_done  (o_download_done),
        .i_prog_sdram_ack (i_prog_sdram_ack),
        .o_prog_sdram_wr  (o_prog_sdram_wr),
        .o_prog_sdram     (o_prog_sdram)
    );

    board_inputs board_inputs_inst (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .i_dipsw_wr      (dipsw_wr),
        .i_joystick0     (i_joystick0),
        .i_joystick1     (i_joystick1),
        .o_dipsw         (o_dipsw),
        .o_download_done (o_download_done),
        .o_in0           (o_in0),
        .o_in1           (o_in1),
        .o_in2           (o_in2)
    );

endmodule

// File: hw/board_inputs.sv
module board_inputs (
    input  logic                         i_EMU_MCLK,
    input  logic                         i_EMU_INITRST,
    input  salamander_pkg::dipsw_wr_t    i_dipsw_wr,
    input  salamander_pkg::joystick_t    i_joystick0,
    input  salamander_pkg::joystick_t    i_joystick1,
    output salamander_pkg::dipsw_t       o_dipsw,
    output logic                         o_download_done,
    output salamander_pkg::board_in_t    o_in0,
    output salamander_pkg::board_in_t    o_in1,
    output salamander_pkg::board_in_t    o_in2
);

    ////////////////////
    // dip switch bank

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            o_dipsw.sw1     <= salamander_pkg::DIPSW1_DEFAULT;
            o_dipsw.sw2     <= salamander_pkg::DIPSW2_DEFAULT;
            o_dipsw.sw3     <= salamander_pkg::DIPSW3_DEFAULT;
            o_download_done <= 1'b0;
        end else if (i_dipsw_wr.strobe && !o_download_done) begin
            case (i_dipsw_wr.sel)
                2'd0: o_dipsw.sw1 <= i_dipsw_wr.data;
                2'd1: o_dipsw.sw2 <= i_dipsw_wr.data;
                2'd2: begin
                    // third switch byte is the last thing the host sends
                    o_dipsw.sw3     <= i_dipsw_wr.data[3:0];
                    o_download_done <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // input ports

    // host joystick bits: 0 right, 1 left, 2 down, 3 up,
    // 4/5 buttons, 7 service, 8 coin, 9 start
    assign o_in0 = {o_dipsw.sw3[2:0],
                    i_joystick1[9], i_joystick0[9],
                    i_joystick0[7],
                    i_joystick1[8], i_joystick0[8]};

    // player 1, cabinet switch on top
    assign o_in1 = {o_dipsw.sw3[3], 1'b1,
                    i_joystick0[5], i_joystick0[4],
                    i_joystick0[2], i_joystick0[3],
                    i_joystick0[0], i_joystick0[1]};

    // player 2
    assign o_in2 = {2'b11,
                    i_joystick1[5], i_joystick1[4],
                    i_joystick1[2], i_joystick1[3],
                    i_joystick1[0], i_joystick1[1]};

endmodule

// File: hw/sdram_prog_writer.sv
module sdram_prog_writer (
    input  logic                            i_EMU_MCLK,
    input  logic                            i_EMU_INITRST,
    input  salamander_pkg::ioctl_t          i_ioctl,
    input  logic                            i_sdram_byte_wr,
    input  logic                            i_download_done,
    input  logic                            i_prog_sdram_ack,
    output logic                            o_prog_sdram_wr,
    output salamander_pkg::sdram_prog_cmd_t o_prog_sdram
);

    logic [2:0]                  region;
    salamander_pkg::sdram_word_t byte_pair;

    // bit 19 is already clear for sdram bytes
    assign region    = i_ioctl.addr[18:16];
    assign byte_pair = {i_ioctl.data, i_ioctl.data};

    ////////////////////
    // write hold

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || i_download_done) begin
            o_prog_sdram_wr   <= 1'b0;
            o_prog_sdram.bank <= '0;
            o_prog_sdram.addr <= salamander_pkg::SDRAM_ADDR_IDLE;
            o_prog_sdram.mask <= '0;
            o_prog_sdram.data <= '1;
        end else if (!o_prog_sdram_wr) begin
            if (i_sdram_byte_wr) begin
                o_prog_sdram_wr   <= 1'b1;
                o_prog_sdram.data <= byte_pair;
                case (region)
                    3'd4, 3'd5: begin
                        // pcm samples, two bytes per word, low byte first
                        o_prog_sdram.bank <= 2'd1;
                        o_prog_sdram.addr <= salamander_pkg::sdram_addr_t'(i_ioctl.addr[16:1]);
                        o_prog_sdram.mask <= i_ioctl.addr[0] ? 2'b01 : 2'b10;
                    end
                    3'd6, 3'd7: begin
                        // 68k program, even rom in the high byte
                        o_prog_sdram.bank <= 2'd0;
                        o_prog_sdram.addr <= salamander_pkg::PROG_BANK0_BASE
                            + salamander_pkg::sdram_addr_t'(i_ioctl.addr[15:0]);
                        o_prog_sdram.mask <= i_ioctl.addr[16] ? 2'b10 : 2'b01;
                    end
                    default: begin
                        // graphics, two roms interleaved by bit 17
                        o_prog_sdram.bank <= 2'd0;
                        o_prog_sdram.addr <= salamander_pkg::sdram_addr_t'(i_ioctl.addr[16:0]);
                        o_prog_sdram.mask <= i_ioctl.addr[17] ? 2'b10 : 2'b01;
                    end
                endcase
            end
        end else if (i_prog_sdram_ack) begin
            o_prog_sdram_wr <= 1'b0;
        end
    end

endmodule

// File: hw/ioctl_region_decoder.sv
module ioctl_region_decoder (
    input  logic                           i_EMU_MCLK,
    input  logic                           i_EMU_INITRST,
    input  salamander_pkg::ioctl_t         i_ioctl,
    input  logic                           i_download_done,
    output logic                           o_prog_sdram_en,
    output logic                           o_sdram_byte_wr,
    output logic                           o_prog_bram_en,
    output logic                           o_prog_bram_wr,
    output salamander_pkg::bram_prog_cmd_t o_prog_bram,
    output salamander_pkg::dipsw_wr_t      o_dipsw_wr
);

    logic is_rom;
    logic is_dipsw;
    logic is_bram_byte;

    assign is_rom       = (i_ioctl.index == salamander_pkg::IDX_ROM);
    assign is_dipsw     = (i_ioctl.index == salamander_pkg::IDX_DIPSW);
    assign is_bram_byte = i_ioctl.addr[salamander_pkg::BRAM_REGION_BIT];

    ////////////////////
    // region enables and block ram write

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || i_download_done) begin
            o_prog_sdram_en <= 1'b0;
            o_prog_bram_en  <= 1'b0;
            o_prog_bram_wr  <= 1'b0;
        end else if (is_rom) begin
            o_prog_sdram_en <= ~is_bram_byte;
            o_prog_bram_en  <= is_bram_byte;
            // write level tracks the host strobe, one cycle late
            o_prog_bram_wr  <= is_bram_byte & i_ioctl.wr;
        end else if (is_dipsw) begin
            o_prog_sdram_en <= 1'b0;
            o_prog_bram_en  <= 1'b0;
            o_prog_bram_wr  <= 1'b0;
        end
    end

    // address, data and chip select for the block ram side
    always_ff @(posedge i_EMU_MCLK) begin
        if (!i_download_done && is_rom && is_bram_byte && i_ioctl.wr) begin
            o_prog_bram.addr      <= i_ioctl.addr[15:0];
            o_prog_bram.data      <= i_ioctl.data;
            // lower 32k is the sound program, upper half the speech commands
            o_prog_bram.sndrom_cs <= ~i_ioctl.addr[15];
            o_prog_bram.vlmrom_cs <= i_ioctl.addr[15];
        end
    end

    ////////////////////
    // sdram strobe and dip switch writes

    assign o_sdram_byte_wr = ~i_download_done & is_rom & ~is_bram_byte & i_ioctl.wr;

    // only registers 0 to 2 exist
    assign o_dipsw_wr.strobe = ~i_download_done & is_dipsw & i_ioctl.wr
                               & (i_ioctl.addr[2:0] < 3'd3);
    assign o_dipsw_wr.sel    = i_ioctl.addr[1:0];
    assign o_dipsw_wr.data   = i_ioctl.data;

endmodule

// File: hw/salamander_pkg.sv
package salamander_pkg;

    ////////////////////
    // plain vector types

    typedef logic [15:0] ioctl_index_t;
    typedef logic [26:0] ioctl_addr_t;
    typedef logic [7:0]  rom_byte_t;
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_word_t;
    typedef logic [1:0]  sdram_bank_t;
    typedef logic [1:0]  byte_mask_t;
    typedef logic [15:0] bram_addr_t;
    typedef logic [15:0] joystick_t;
    typedef logic [7:0]  board_in_t;

    ////////////////////
    // constants

    // download index values from the host menu
    localparam ioctl_index_t IDX_ROM   = 16'd0;
    localparam ioctl_index_t IDX_DIPSW = 16'd254;

    // addr bit 19 splits sdram bytes from block ram bytes
    localparam int BRAM_REGION_BIT = 19;

    // main cpu program lives above the graphics data in bank 0
    localparam sdram_addr_t PROG_BANK0_BASE = 22'h02_0000;

    // switch defaults, 1 means the switch is off
    localparam rom_byte_t   DIPSW1_DEFAULT = 8'hFF;
    localparam rom_byte_t   DIPSW2_DEFAULT = 8'h42;
    localparam logic [3:0]  DIPSW3_DEFAULT = 4'hF;

    localparam sdram_addr_t SDRAM_ADDR_IDLE = '1;

    ////////////////////
    // bundles

    typedef struct packed {
        ioctl_index_t index;
        ioctl_addr_t  addr;
        rom_byte_t    data;
        logic         wr;
    } ioctl_t;

    typedef struct packed {
        sdram_bank_t bank;
        sdram_addr_t addr;
        byte_mask_t  mask;
        sdram_word_t data;
    } sdram_prog_cmd_t;

    typedef struct packed {
        bram_addr_t addr;
        rom_byte_t  data;
        logic       sndrom_cs;
        logic       vlmrom_cs;
    } bram_prog_cmd_t;

    typedef struct packed {
        logic       strobe;
        logic [1:0] sel;
        rom_byte_t  data;
    } dipsw_wr_t;

    typedef struct packed {
        rom_byte_t  sw1;
        rom_byte_t  sw2;
        logic [3:0] sw3;
    } dipsw_t;

endpackage
